/* disc_ctrl_top.f */
+incdir+rtl
rtl/disc_ctrl_pkg.sv
rtl/host_regs.sv
rtl/sram_ctrl.sv
rtl/step_ctrl.sv
rtl/disc_ctrl_top.sv
testbench/tb_checker.sv
testbench/tb_disc_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the disc controller testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_disc_ctrl \
	-f disc_ctrl_top.f -o Vtb_disc_ctrl > build.log 2>&1 \
	&& ./obj_dir/Vtb_disc_ctrl > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || grep -q "TESTBENCH PASSED" sim.log

/* testbench/disc_ctrl_stimulus.txt */
# W addr data: write hex data to hex addr | R addr data: read addr, expect hex data
# S pulses dir: wait for stepping to end, expect decimal pulses and dir | X: random scratch test
# Identification and fixed patterns
R 04 55
R 05 DD
R 06 1B
R 07 00
R 32 55
R 33 AA
X
X
# Status at address 0 after reset: empty, track 0
R 0F 5A
# Address to all ones, upper byte masked, full flag
W 00 FF
W 01 FF
W 02 FF
R 00 FF
R 01 FF
R 02 07
R 0F 59
# Write at the top wraps to zero
W 03 5E
R 0F 5A
R 00 00
# SRAM data run
W 00 40
W 01 12
W 02 FD
R 02 05
W 03 A1
W 03 B2
W 03 C3
R 00 43
W 00 40
R 03 A1
R 03 B2
R 03 C3
R 00 43
R 01 12
R 02 05
# Drive control pins
W 04 81
W 04 3C
W 04 00
# Stepping, in by 2 then out by 5 from track 2
W F0 02
R F0 02
W FF 82
S 2 1
W FF 05
S 2 0
R 0F 58

/* testbench/tb_disc_ctrl.sv */
`include "disc_ctrl_macros.svh"

module tb_disc_ctrl import disc_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int strobe_cycles = 3;	// wr and rd width
	localparam int gap_cycles    = 6;	// Between accesses
	localparam int step_timeout  = 20000;

	logic                    CLK_MASTER;
	logic                    arst_n;
	host_bus_t               host_bus;
	logic [`HOST_DATA_W-1:0] host_rdata;
	logic [`SRAM_ADDR_W-1:0] sram_a;
	logic [`HOST_DATA_W-1:0] sram_dq_in, sram_dq_out;
	logic                    sram_we_n, sram_oe_n, sram_ce_n;
	logic                    fd_index_in, fd_wrprot_in, fd_rdy_in, fd_dens_in, fd_track0_in;
	logic                    fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_step, fd_dir;
	logic [3:0]              fd_drvsel;

	// Expected values to the checker
	logic [7:0] exp_addr, exp_rdata, exp_drive;
	logic [6:0] exp_pulses;
	logic       exp_dir, drive_check, step_check;
	int         checks, mismatches;
	int         other_errors = 0;	// Timeouts and file trouble

	logic [7:0] mem [0:(1 << `SRAM_ADDR_W) - 1];	// 512 KB SRAM
	int         head_pos = 0;	// Track under the head
	logic       step_seen = 1'b0;

	always #5 CLK_MASTER = ~CLK_MASTER;

	disc_ctrl_top uut (.*);

	tb_checker u_checker (
		.CLK_MASTER, .arst_n, .rd(host_bus.rd), .host_rdata, .exp_addr, .exp_rdata,
		.fd_dens_out, .fd_inuse, .fd_drvsel, .fd_moten, .fd_sidesel, .drive_check,
		.exp_drive, .fd_step, .fd_dir, .step_check, .exp_pulses, .exp_dir,
		.checks, .mismatches
	);

	////////////////////////////////////////
	// SRAM and drive models

	// Async read, outputs only while selected and enabled
	assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ? mem[sram_a] : 'x;

	always @(posedge CLK_MASTER) begin
		if (!sram_ce_n && !sram_we_n) mem[sram_a] = sram_dq_out;
	end

	// One track per step pulse, never below 0
	always @(posedge CLK_MASTER) begin
		if (fd_step && !step_seen) begin
			if (fd_dir)            head_pos <= head_pos + 1;
			else if (head_pos > 0) head_pos <= head_pos - 1;
		end
		step_seen <= fd_step;
	end

	assign fd_track0_in = (head_pos == 0);

	////////////////////////////////////////
	// Host bus, driven on falling edges

	task latch_address(input logic [7:0] addr);
		@(negedge CLK_MASTER);
		host_bus.ale_high = 1'b1;
		host_bus.wdata    = 8'h00;	// High byte not decoded
		@(negedge CLK_MASTER);
		host_bus.ale_high = 1'b0;
		host_bus.ale_low  = 1'b1;
		host_bus.wdata    = addr;
		@(negedge CLK_MASTER);
		host_bus.ale_low  = 1'b0;
	endtask

	task write_register(input logic [7:0] addr, input logic [7:0] data);
		latch_address(addr);
		host_bus.wdata = data;
		host_bus.wr    = 1'b1;
		repeat (strobe_cycles) @(negedge CLK_MASTER);
		host_bus.wr = 1'b0;
		repeat (gap_cycles) @(negedge CLK_MASTER);
	endtask

	// Checker compares in the third rd cycle
	task read_register(input logic [7:0] addr, input logic [7:0] expected);
		latch_address(addr);
		exp_addr    = addr;
		exp_rdata   = expected;
		host_bus.rd = 1'b1;
		repeat (strobe_cycles) @(negedge CLK_MASTER);
		host_bus.rd = 1'b0;
		repeat (gap_cycles) @(negedge CLK_MASTER);
	endtask

	task run_scratch_test();
		logic [7:0] value;
		value = 8'($urandom);
		write_register(`REG_SCRATCH, value);
		read_register(`REG_SCRATCH, value);
		read_register(`REG_SCRATCH_INV, ~value);
	endtask

	task request_drive_check(input logic [7:0] data);
		exp_drive   = data;
		drive_check = 1'b1;
		@(negedge CLK_MASTER);
		drive_check = 1'b0;
	endtask

	task wait_stepping_clear();
		int cycles;
		cycles = 0;
		while (uut.stepping && cycles < step_timeout) begin
			@(negedge CLK_MASTER);
			cycles++;
		end
		if (uut.stepping) begin
			other_errors++;
			$display("Timeout at time %0t: stepping still set after %0d cycles", $time, cycles);
		end
	endtask

	task request_step_check(input int pulses, input int dir);
		exp_pulses = 7'(pulses);
		exp_dir    = dir[0];
		step_check = 1'b1;
		@(negedge CLK_MASTER);
		step_check = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		int         fd;
		int         n;
		int         pulses, dir;
		string      op;
		string      line;
		logic [7:0] addr, data;
		void'($urandom(32'h814d));
		for (int i = 0; i < (1 << `SRAM_ADDR_W); i++) mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
		CLK_MASTER   = 1'b0;
		arst_n       = 1'b0;
		host_bus     = '0;
		fd_index_in  = 1'b0;
		fd_wrprot_in = 1'b0;
		fd_rdy_in    = 1'b1;
		fd_dens_in   = 1'b1;
		exp_addr     = '0;
		exp_rdata    = '0;
		exp_drive    = '0;
		exp_pulses   = '0;
		exp_dir      = 1'b0;
		drive_check  = 1'b0;
		step_check   = 1'b0;
		repeat (4) @(negedge CLK_MASTER);
		arst_n = 1'b1;
		repeat (2) @(negedge CLK_MASTER);

		fd = $fopen("testbench/disc_ctrl_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the stimulus file testbench/disc_ctrl_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", op);
				if (n != 1) break;	// End of file
				if (op[0] == "#") begin
					n = $fgets(line, fd);	// Rest of a comment line
				end else if (op == "W") begin
					n = $fscanf(fd, "%h %h", addr, data);
					if (addr == `REG_DRIVE_CTRL) begin
						// Complement first so every pin is seen both ways
						write_register(addr, ~data);
						request_drive_check(~data);
					end
					write_register(addr, data);
					if (addr == `REG_DRIVE_CTRL) request_drive_check(data);
				end else if (op == "R") begin
					n = $fscanf(fd, "%h %h", addr, data);
					read_register(addr, data);
				end else if (op == "S") begin
					n = $fscanf(fd, "%d %d", pulses, dir);
					wait_stepping_clear();
					request_step_check(pulses, dir);
				end else if (op == "X") begin
					run_scratch_test();
				end else begin
					other_errors++;
					$display("Unknown operation %s in the stimulus file", op);
				end
			end
			$fclose(fd);
		end

		repeat (2) @(negedge CLK_MASTER);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* testbench/tb_checker.sv */
module tb_checker (
	input  logic       CLK_MASTER,
	input  logic       arst_n,
	// Host read side
	input  logic       rd,
	input  logic [7:0] host_rdata,
	input  logic [7:0] exp_addr,
	input  logic [7:0] exp_rdata,
	// Drive pins, active low
	input  logic       fd_dens_out,
	input  logic       fd_inuse,
	input  logic [3:0] fd_drvsel,
	input  logic       fd_moten,
	input  logic       fd_sidesel,
	input  logic       drive_check,	// One cycle request
	input  logic [7:0] exp_drive,
	// Stepper
	input  logic       fd_step,
	input  logic       fd_dir,
	input  logic       step_check,	// One cycle request
	input  logic [6:0] exp_pulses,
	input  logic       exp_dir,
	output int         checks,
	output int         mismatches
);

	timeunit 1ns;
	timeprecision 1ps;

	int         rd_cycles;	// Cycles of rd seen so far
	int         pulses_in, pulses_out;	// Since the last step check
	logic       step_q;
	logic [7:0] drive_pins;

	// Register bit order: side, motor, drive_sel, in_use, density
	assign drive_pins = {fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out};

	always @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			rd_cycles  = 0;
			pulses_in  = 0;
			pulses_out = 0;
			step_q     = 1'b0;
			checks     = 0;
			mismatches = 0;
		end else begin
			////////////////////////////////////////
			// Readback, third cycle of rd
			if (rd) begin
				if (rd_cycles == 2) begin
					checks++;
					if (host_rdata !== exp_rdata) begin
						mismatches++;
						$display("Mismatch at time %0t: read of %02h gave %02h, expected %02h",
							$time, exp_addr, host_rdata, exp_rdata);
					end
				end
				rd_cycles++;
			end else begin
				rd_cycles = 0;
			end

			// Pins carry the inverse of the register
			if (drive_check) begin
				checks++;
				if (drive_pins !== ~exp_drive) begin
					mismatches++;
					$display("Mismatch at time %0t: drive pins %b after writing %02h, expected %b",
						$time, drive_pins, exp_drive, ~exp_drive);
				end
			end

			////////////////////////////////////////
			// Step pulses, split by direction
			if (fd_step && !step_q) begin
				if (fd_dir) pulses_in++;	// Inward
				else        pulses_out++;
			end
			step_q = fd_step;

			if (step_check) begin
				checks++;
				// All pulses in the expected direction, none the other way
				if ((exp_dir ? pulses_in : pulses_out) != int'(exp_pulses) ||
					(exp_dir ? pulses_out : pulses_in) != 0) begin
					mismatches++;
					$display("Mismatch at time %0t: %0d inward and %0d outward pulses, expected %0d %s",
						$time, pulses_in, pulses_out, exp_pulses, exp_dir ? "inward" : "outward");
				end
				pulses_in  = 0;
				pulses_out = 0;
			end
		end
	end

endmodule

/* rtl/disc_ctrl_top.sv */
`include "disc_ctrl_macros.svh"

module disc_ctrl_top import disc_ctrl_pkg::*; (
	input  logic                    CLK_MASTER,
	input  logic                    arst_n,
	// Host port
	input  host_bus_t               host_bus,
	output logic [`HOST_DATA_W-1:0] host_rdata,
	// SRAM
	output logic [`SRAM_ADDR_W-1:0] sram_a,
	input  logic [`HOST_DATA_W-1:0] sram_dq_in,
	output logic [`HOST_DATA_W-1:0] sram_dq_out,
	output logic                    sram_we_n,
	output logic                    sram_oe_n,
	output logic                    sram_ce_n,
	// Drive status, readback only
	input  logic                    fd_index_in,
	input  logic                    fd_wrprot_in,
	input  logic                    fd_rdy_in,
	input  logic                    fd_dens_in,
	input  logic                    fd_track0_in,
	// Drive outputs, active low except step and dir
	output logic                    fd_dens_out,
	output logic                    fd_inuse,
	output logic [3:0]              fd_drvsel,
	output logic                    fd_moten,
	output logic                    fd_sidesel,
	output logic                    fd_step,
	output logic                    fd_dir
);

	sram_cmd_t               sram_cmd;
	step_cmd_t               step_cmd;
	drive_ctrl_t             drive_ctrl;
	fd_status_t              fd_status;
	logic [`HOST_DATA_W-1:0] step_rate;
	logic [`HOST_DATA_W-1:0] rd_latch;
	logic                    sram_empty, sram_full;
	logic                    stepping;

	assign fd_status = '{index: fd_index_in, track0: fd_track0_in, wrprot: fd_wrprot_in,
		ready: fd_rdy_in, dens: fd_dens_in};

	host_regs u_host_regs (
		.CLK_MASTER    (CLK_MASTER),
		.arst_n        (arst_n),
		.bus           (host_bus),
		.rdata         (host_rdata),
		.sram_cmd      (sram_cmd),
		.sram_addr     (sram_a),
		.sram_rd_latch (rd_latch),
		.sram_empty    (sram_empty),
		.sram_full     (sram_full),
		.step_cmd      (step_cmd),
		.step_rate     (step_rate),
		.stepping      (stepping),
		.fd_status     (fd_status),
		.drive_ctrl    (drive_ctrl)
	);

	sram_ctrl u_sram_ctrl (
		.CLK_MASTER  (CLK_MASTER),
		.arst_n      (arst_n),
		.cmd         (sram_cmd),
		.sram_a      (sram_a),
		.sram_dq_in  (sram_dq_in),
		.sram_dq_out (sram_dq_out),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.rd_latch    (rd_latch),
		.empty       (sram_empty),
		.full        (sram_full)
	);

	step_ctrl u_step_ctrl (
		.CLK_MASTER (CLK_MASTER),
		.arst_n     (arst_n),
		.cmd        (step_cmd),
		.step_rate  (step_rate),
		.track0     (fd_track0_in),
		.fd_step    (fd_step),
		.fd_dir     (fd_dir),
		.stepping   (stepping)
	);

	////////////////////////////////////////
	// Drive pins

	assign fd_dens_out = ~drive_ctrl.density;
	assign fd_inuse    = ~drive_ctrl.in_use;
	assign fd_drvsel   = ~drive_ctrl.drive_sel;
	assign fd_moten    = ~drive_ctrl.motor;
	assign fd_sidesel  = ~drive_ctrl.side;
	assign sram_ce_n   = 1'b0;	// Always selected for fastest access

endmodule

/* rtl/step_ctrl.sv */
`include "disc_ctrl_macros.svh"

module step_ctrl import disc_ctrl_pkg::*; #(
	parameter int unsigned TICKS = `TICKS_250US	// Clocks per 250 us tick
) (
	input  logic                    CLK_MASTER,
	input  logic                    arst_n,
	input  step_cmd_t               cmd,
	input  logic [`HOST_DATA_W-1:0] step_rate,
	input  logic                    track0,
	output logic                    fd_step,
	output logic                    fd_dir,
	output logic                    stepping
);

	localparam int unsigned tick_w = $clog2(TICKS);

	step_state_e             state;
	logic [tick_w-1:0]       tick_cnt;
	logic                    tick;
	logic                    start;
	logic                    dir_q;
	logic [6:0]              remaining;	// Pulses left after the current one
	logic [`HOST_DATA_W-1:0] rate_cnt;	// Ticks into the step period

	// Outward at track 0 has nothing to do
	assign start = (state == STEP_IDLE) && cmd.go && (cmd.count != '0) &&
		(cmd.dir || !track0);

	////////////////////////////////////////
	// 250 us tick, restarted with each command

	assign tick = (tick_cnt == tick_w'(TICKS - 1));

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
		end else if (start || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Step sequencer
	// Period is step_rate + 1 ticks, first tick is the pulse

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			state     <= STEP_IDLE;
			dir_q     <= 1'b0;
			remaining <= '0;
			rate_cnt  <= '0;
		end else if (start) begin
			state     <= STEP_PULSE;	// Go while busy never gets here
			dir_q     <= cmd.dir;
			remaining <= cmd.count - 1'b1;
			rate_cnt  <= '0;
		end else if (state != STEP_IDLE && tick) begin
			if (state == STEP_PULSE && remaining == '0) begin
				state <= STEP_IDLE;	// Last pulse over
			end else if (rate_cnt == step_rate) begin
				// Period boundary
				rate_cnt <= '0;
				if (!dir_q && track0) begin
					state <= STEP_IDLE;	// Head reached track 0
				end else begin
					state     <= STEP_PULSE;
					remaining <= remaining - 1'b1;
				end
			end else begin
				rate_cnt <= rate_cnt + 1'b1;
				state    <= STEP_GAP;
			end
		end
	end

	assign fd_step  = (state == STEP_PULSE);
	assign fd_dir   = dir_q;
	assign stepping = (state != STEP_IDLE);

	// No outward pulse with the head at track 0
	a_no_outward_at_track0: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		$rose(fd_step) && !fd_dir |-> $past(!track0));

	// Every pulse lasts a whole tick
	a_pulse_width: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		$rose(fd_step) |-> fd_step [*TICKS]);

endmodule

/* rtl/sram_ctrl.sv */
`include "disc_ctrl_macros.svh"

module sram_ctrl import disc_ctrl_pkg::*; (
	input  logic                    CLK_MASTER,
	input  logic                    arst_n,
	input  sram_cmd_t               cmd,
	output logic [`SRAM_ADDR_W-1:0] sram_a,
	input  logic [`HOST_DATA_W-1:0] sram_dq_in,
	output logic [`HOST_DATA_W-1:0] sram_dq_out,
	output logic                    sram_we_n,
	output logic                    sram_oe_n,
	output logic [`HOST_DATA_W-1:0] rd_latch,
	output logic                    empty,
	output logic                    full
);

	mwc_state_e              state;
	logic [`SRAM_ADDR_W-1:0] addr;
	logic                    addr_inc;
	logic [`HOST_DATA_W-1:0] wr_data;

	////////////////////////////////////////
	// Memory write controller
	// Outputs are set on entry to each state so they line up with it

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			state     <= MWC_IDLE;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;	// Bus released during reset
		end else begin
			case (state)
				MWC_IDLE: begin
					sram_we_n <= 1'b1;
					if (cmd.write_data) begin
						state     <= MWC_OE_OFF;
						sram_oe_n <= 1'b1;	// Get the SRAM off the bus first
					end else begin
						sram_oe_n <= 1'b0;	// Keep read data flowing
					end
				end
				MWC_OE_OFF: begin
					state     <= MWC_WRITE;
					sram_we_n <= 1'b0;	// Data already set up
				end
				MWC_WRITE: begin
					state     <= MWC_WRITE_END;
					sram_we_n <= 1'b1;	// Single cycle WE
				end
				MWC_WRITE_END: state <= MWC_INC_ADDR;	// Hold time
				MWC_INC_ADDR: begin
					state     <= MWC_IDLE;
					sram_oe_n <= 1'b0;
				end
				default: state <= MWC_IDLE;
			endcase
		end
	end

	// Write byte, taken with the command
	always_ff @(posedge CLK_MASTER) begin
		if (state == MWC_IDLE && cmd.write_data) wr_data <= cmd.wdata;
	end

	assign sram_dq_out = wr_data;

	// Follows the addressed byte while idle
	// The address only moves after rd falls so the byte is steady for the host read
	always_ff @(posedge CLK_MASTER) begin
		if (state == MWC_IDLE && !sram_oe_n) rd_latch <= sram_dq_in;
	end

	////////////////////////////////////////
	// Address counter

	assign addr_inc = (state == MWC_INC_ADDR) || cmd.read_done;

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr <= '0;
		end else if (cmd.load_low) begin
			addr[7:0] <= cmd.wdata;
		end else if (cmd.load_high) begin
			addr[15:8] <= cmd.wdata;
		end else if (cmd.load_upper) begin
			addr[18:16] <= cmd.wdata[2:0];
		end else if (addr_inc) begin
			addr <= addr + 1'b1;	// Wraps at the top
		end
	end

	assign sram_a = addr;
	assign empty  = (addr == '0);
	assign full   = &addr;

	// Bus contention check between the two enables
	a_we_needs_oe_off: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		!sram_we_n |-> sram_oe_n);

	// Host must keep the access gap or the write is dropped
	a_write_in_idle: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		cmd.write_data |-> (state == MWC_IDLE));

endmodule

/* rtl/host_regs.sv */
`include "disc_ctrl_macros.svh"

module host_regs import disc_ctrl_pkg::*; (
	input  logic                    CLK_MASTER,
	input  logic                    arst_n,
	input  host_bus_t               bus,
	output logic [`HOST_DATA_W-1:0] rdata,
	output sram_cmd_t               sram_cmd,
	input  logic [`SRAM_ADDR_W-1:0] sram_addr,
	input  logic [`HOST_DATA_W-1:0] sram_rd_latch,
	input  logic                    sram_empty,
	input  logic                    sram_full,
	output step_cmd_t               step_cmd,
	output logic [`HOST_DATA_W-1:0] step_rate,
	input  logic                    stepping,
	input  fd_status_t              fd_status,
	output drive_ctrl_t             drive_ctrl
);

	localparam logic [15:0] id_type    = `MCO_TYPE;
	localparam logic [15:0] id_version = `MCO_VERSION;

	logic [15:0]             addr;		// Latched host address
	logic [7:0]              reg_sel;	// Decoded part
	logic                    wr_q, rd_q;
	logic                    wr_pulse;	// One cycle, one clock after wr rises
	logic                    rd_done;	// One cycle, one clock after rd falls on SRAM_DATA
	logic [`HOST_DATA_W-1:0] scratch;

	assign reg_sel = addr[7:0];

	////////////////////////////////////////
	// Address latch and strobe edges

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr     <= '0;
			wr_q     <= 1'b0;
			rd_q     <= 1'b0;
			wr_pulse <= 1'b0;
			rd_done  <= 1'b0;
		end else begin
			if (bus.ale_high) addr[15:8] <= bus.wdata;	// Any cycle with ALE high
			if (bus.ale_low)  addr[7:0]  <= bus.wdata;
			wr_q     <= bus.wr;
			rd_q     <= bus.rd;
			wr_pulse <= bus.wr && !wr_q;	// Rising edge of wr
			rd_done  <= !bus.rd && rd_q && (reg_sel == SRAM_DATA);
		end
	end

	////////////////////////////////////////
	// Register writes

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			drive_ctrl <= '0;	// All drive pins inactive
			step_rate  <= '0;
			scratch    <= '0;
		end else if (wr_pulse) begin
			// wdata still held, wr lasts 3 cycles min
			case (reg_sel)
				DRIVE_CTRL: drive_ctrl <= drive_ctrl_t'(bus.wdata);
				STEP_RATE:  step_rate  <= bus.wdata;
				SCRATCH:    scratch    <= bus.wdata;
				default: ;	// Address and data ports decoded below
			endcase
		end
	end

	// Command pulses to the SRAM and step blocks
	always_comb begin
		sram_cmd.load_low   = wr_pulse && (reg_sel == ADDR_LOW);
		sram_cmd.load_high  = wr_pulse && (reg_sel == ADDR_HIGH);
		sram_cmd.load_upper = wr_pulse && (reg_sel == ADDR_UPPER);
		sram_cmd.write_data = wr_pulse && (reg_sel == SRAM_DATA);
		sram_cmd.read_done  = rd_done;
		sram_cmd.wdata      = bus.wdata;

		step_cmd.go    = wr_pulse && (reg_sel == STEP_CMD);
		step_cmd.dir   = bus.wdata[7];	// Top bit is direction
		step_cmd.count = bus.wdata[6:0];
	end

	////////////////////////////////////////
	// Readback, straight from the latched address

	always_comb begin
		case (reg_sel)
			ADDR_LOW:     rdata = sram_addr[7:0];
			ADDR_HIGH:    rdata = sram_addr[15:8];
			ADDR_UPPER:   rdata = {5'b00000, sram_addr[18:16]};	// Only 3 bits exist
			SRAM_DATA:    rdata = sram_rd_latch;
			DRIVE_CTRL:   rdata = id_type[7:0];	// Write-only register, ID on read
			ID_TYPE_HIGH: rdata = id_type[15:8];
			ID_VER_LOW:   rdata = id_version[7:0];
			ID_VER_HIGH:  rdata = id_version[15:8];
			STATUS:       rdata = {fd_status, stepping, sram_empty, sram_full};
			SCRATCH:      rdata = scratch;
			SCRATCH_INV:  rdata = ~scratch;	// Bus bit test
			FIXED_55:     rdata = 8'h55;
			FIXED_AA:     rdata = 8'hAA;
			STEP_RATE:    rdata = step_rate;
			default:      rdata = '0;	// Unmapped
		endcase
	end

endmodule

/* rtl/disc_ctrl_pkg.sv */
`include "disc_ctrl_macros.svh"

package disc_ctrl_pkg;

	// Host register addresses
	typedef enum logic [7:0] {
		ADDR_LOW     = `REG_ADDR_LOW,
		ADDR_HIGH    = `REG_ADDR_HIGH,
		ADDR_UPPER   = `REG_ADDR_UPPER,
		SRAM_DATA    = `REG_SRAM_DATA,
		DRIVE_CTRL   = `REG_DRIVE_CTRL,	// Reads back as ID type low
		ID_TYPE_HIGH = `REG_ID_TYPE_HIGH,
		ID_VER_LOW   = `REG_ID_VER_LOW,
		ID_VER_HIGH  = `REG_ID_VER_HIGH,
		STATUS       = `REG_STATUS,
		SCRATCH      = `REG_SCRATCH,
		SCRATCH_INV  = `REG_SCRATCH_INV,
		FIXED_55     = `REG_FIXED_55,
		FIXED_AA     = `REG_FIXED_AA,
		STEP_RATE    = `REG_STEP_RATE,
		STEP_CMD     = `REG_STEP_CMD
	} reg_addr_e;

	// Memory write controller
	typedef enum logic [2:0] {
		MWC_IDLE,	// OE on, waiting for a write
		MWC_OE_OFF,	// SRAM outputs off
		MWC_WRITE,	// WE pulse
		MWC_WRITE_END,
		MWC_INC_ADDR
	} mwc_state_e;

	// Stepper
	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_PULSE,	// Step pin high for one tick
		STEP_GAP	// Rest of the step period
	} step_state_e;

	////////////////////////////////////////
	// Buses between blocks

	typedef struct packed {
		logic                    ale_high;
		logic                    ale_low;
		logic                    rd;
		logic                    wr;
		logic [`HOST_DATA_W-1:0] wdata;
	} host_bus_t;

	// One-cycle pulses from the register decoder
	typedef struct packed {
		logic                    load_low;
		logic                    load_high;
		logic                    load_upper;
		logic                    write_data;
		logic                    read_done;
		logic [`HOST_DATA_W-1:0] wdata;
	} sram_cmd_t;

	typedef struct packed {
		logic       go;
		logic       dir;	// 1 = inward
		logic [6:0] count;
	} step_cmd_t;

	// Same bit order as the host sees in the register
	typedef struct packed {
		logic       side;
		logic       motor;
		logic [3:0] drive_sel;
		logic       in_use;
		logic       density;
	} drive_ctrl_t;

	typedef struct packed {
		logic index;
		logic track0;
		logic wrprot;
		logic ready;
		logic dens;
	} fd_status_t;

endpackage

/* rtl/disc_ctrl_macros.svh */
`ifndef DISC_CTRL_MACROS_SVH
`define DISC_CTRL_MACROS_SVH

////////////////////////////////////////
// Widths

`define SRAM_ADDR_W	19	// 512K x 8 SRAM
`define HOST_DATA_W	8	// Host parallel port

////////////////////////////////////////
// Identification

`define MCO_TYPE	16'hDD55	// Microcode type
`define MCO_VERSION	16'h001B	// Microcode version

// Master clock cycles per 250 us tick
// Short for simulation, 20000 at 80 MHz on hardware
`define TICKS_250US	16

////////////////////////////////////////
// Host register map, low address byte only

`define REG_ADDR_LOW	8'h00	// SRAM address [7:0]
`define REG_ADDR_HIGH	8'h01	// SRAM address [15:8]
`define REG_ADDR_UPPER	8'h02	// SRAM address [18:16]
`define REG_SRAM_DATA	8'h03	// SRAM data port
`define REG_DRIVE_CTRL	8'h04	// Drive control write, ID type low read
`define REG_ID_TYPE_HIGH	8'h05
`define REG_ID_VER_LOW	8'h06
`define REG_ID_VER_HIGH	8'h07
`define REG_STATUS	8'h0F	// Drive and controller status
`define REG_SCRATCH	8'h30
`define REG_SCRATCH_INV	8'h31
`define REG_FIXED_55	8'h32
`define REG_FIXED_AA	8'h33
`define REG_STEP_RATE	8'hF0
`define REG_STEP_CMD	8'hFF

`endif
